// ==== fetch_cfg_pkg.sv ====
////////////////////////////////////////////////////////////
// Instruction fetch unit configuration
// Address and word widths, the reset vector and the
// sequential fetch step, shared by the fetch RTL and
// the testbench
////////////////////////////////////////////////////////////

package fetch_cfg_pkg;

  ////////////////////////////////////////////////////////////
  // Widths
  ////////////////////////////////////////////////////////////

  // Program counter width
  localparam int PC_W = 32;

  // One fetched instruction word
  localparam int INSTR_W = 32;

  // Address type used on every PC path
  typedef logic [PC_W-1:0] pc_t;

  ////////////////////////////////////////////////////////////
  // Fetch addresses
  ////////////////////////////////////////////////////////////

  // Step to the next word, only RV32 words are fetched
  localparam pc_t PC_INCR = pc_t'(4);

  // First fetch address after reset
  localparam pc_t RESET_PC = 32'h0000_1000;

endpackage

// ==== rv_instr_pkg.sv ====
////////////////////////////////////////////////////////////
// RV32 instruction encodings seen by the fetch pre-decoder
// Opcodes of the jumps and branches, their immediate
// widths and a union that reads one word as B or J format
////////////////////////////////////////////////////////////

package rv_instr_pkg;

  ////////////////////////////////////////////////////////////
  // Opcodes
  ////////////////////////////////////////////////////////////

  // Unconditional jump and link
  localparam logic [6:0] OPC_JAL = 7'b110_1111;

  // BEQ, BNE, BLT, BGE, BLTU, BGEU
  localparam logic [6:0] OPC_BRANCH = 7'b110_0011;

  // Offset widths including the implied zero bit 0
  localparam int B_IMM_W = 13;
  localparam int J_IMM_W = 21;

  ////////////////////////////////////////////////////////////
  // Instruction formats
  ////////////////////////////////////////////////////////////

  // B format, offset bits 12 and 10:5 on top, 4:1 and 11 below
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    logic [6:0] opcode;
  } b_fmt_t;

  // J format, offset bit order 20, 10:1, 11, 19:12
  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  // Same 32-bit word, two decodings
  typedef union packed {
    b_fmt_t b;
    j_fmt_t j;
  } instr_u;

endpackage

// ==== instr_predecode.sv ====
////////////////////////////////////////////////////////////
// Fetch pre-decoder
// Looks at the returning instruction word, flags JAL and
// conditional branches and builds their sign-extended
// offset for the next-PC prediction. Purely combinational
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module instr_predecode (
  input  rv_instr_pkg::instr_u instr,
  output logic                 is_jal,
  output logic                 is_bxx,
  output fetch_cfg_pkg::pc_t   bjp_imm
);

  import fetch_cfg_pkg::*;
  import rv_instr_pkg::*;

  // Raw offsets, bit 0 is always zero
  logic [B_IMM_W-1:0] b_imm;
  logic [J_IMM_W-1:0] j_imm;

  // Opcode match, both views share the opcode field
  assign is_jal = (instr.j.opcode == OPC_JAL);
  assign is_bxx = (instr.b.opcode == OPC_BRANCH);

  // Reassemble the scrambled B offset
  assign b_imm = {instr.b.imm_12,
                  instr.b.imm_11,
                  instr.b.imm_10_5,
                  instr.b.imm_4_1,
                  1'b0};

  // Reassemble the scrambled J offset
  assign j_imm = {instr.j.imm_20,
                  instr.j.imm_19_12,
                  instr.j.imm_11,
                  instr.j.imm_10_1,
                  1'b0};

  // Sign extend the matching offset to a full address
  always_comb begin
    bjp_imm = '0;
    if (is_jal) begin
      bjp_imm = {{(PC_W-J_IMM_W){j_imm[J_IMM_W-1]}}, j_imm};
    end else if (is_bxx) begin
      bjp_imm = {{(PC_W-B_IMM_W){b_imm[B_IMM_W-1]}}, b_imm};
    end
    // Anything else leaves the offset at zero
  end

endmodule

// ==== next_pc_gen.sv ====
////////////////////////////////////////////////////////////
// Next PC generation and fetch channel control
// Owns the PC register, the reset fetch, the outstanding
// request flag and the delayed flush. Picks the next fetch
// address from flush, prediction, reset vector or PC+4
// and drives the request and response handshakes
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module next_pc_gen (
  input  logic               clk,
  input  logic               reset,
  // From the pre-decoder
  input  logic               is_jal,
  input  logic               is_bxx,
  input  fetch_cfg_pkg::pc_t bjp_imm,
  // Flush from execute
  input  logic               pipe_flush_req,
  input  fetch_cfg_pkg::pc_t pipe_flush_add_op1,
  input  fetch_cfg_pkg::pc_t pipe_flush_add_op2,
  // Fetch request channel
  output logic               ifu_req_valid,
  input  logic               ifu_req_ready,
  output fetch_cfg_pkg::pc_t ifu_req_pc,
  // Fetch response channel
  input  logic               ifu_rsp_valid,
  output logic               ifu_rsp_ready,
  // Toward the instruction register
  input  logic               ir_ready,
  output logic               ir_load,
  output fetch_cfg_pkg::pc_t ir_pc,
  output logic               prdt_taken
);

  import fetch_cfg_pkg::*;

  logic req_hsked;
  logic rsp_hsked;
  logic reset_flag_r;
  logic reset_req_r;
  logic reset_req_set;
  logic reset_req_clr;
  logic dly_flush_r;
  logic dly_flush_set;
  logic dly_flush_clr;
  logic flush_real;
  logic out_flag_r;
  logic new_req_condi;
  logic bjp_req;
  pc_t  pc_r;
  pc_t  pc_add_op1;
  pc_t  pc_add_op2;
  pc_t  pc_nxt_pre;
  pc_t  pc_nxt;

  assign req_hsked = ifu_req_valid & ifu_req_ready;
  assign rsp_hsked = ifu_rsp_valid & ifu_rsp_ready;

  ////////////////////////////////////////////////////////////
  // Reset fetch
  ////////////////////////////////////////////////////////////

  // High in reset and one cycle after it
  always_ff @(posedge clk) begin
    reset_flag_r <= reset;
  end

  // One reset-vector request, held until it is taken
  assign reset_req_set = ~reset_req_r & reset_flag_r;
  assign reset_req_clr = reset_req_r & req_hsked;

  always_ff @(posedge clk) begin
    if (reset) begin
      reset_req_r <= 1'b0;
    end else if (reset_req_set) begin
      reset_req_r <= 1'b1;
    end else if (reset_req_clr) begin
      reset_req_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Flush tracking
  ////////////////////////////////////////////////////////////

  // Flush always acked; if its fetch cannot go out now, remember it
  assign dly_flush_set = pipe_flush_req & ~req_hsked;
  assign dly_flush_clr = dly_flush_r & req_hsked;

  always_ff @(posedge clk) begin
    if (reset) begin
      dly_flush_r <= 1'b0;
    end else if (dly_flush_set) begin
      dly_flush_r <= 1'b1;
    end else if (dly_flush_clr) begin
      dly_flush_r <= 1'b0;
    end
  end

  // Live or pending flush, responses get dropped while high
  assign flush_real = pipe_flush_req | dly_flush_r;

  ////////////////////////////////////////////////////////////
  // Outstanding request
  ////////////////////////////////////////////////////////////

  // Set on request, cleared on response, set wins
  always_ff @(posedge clk) begin
    if (reset) begin
      out_flag_r <= 1'b0;
    end else if (req_hsked) begin
      out_flag_r <= 1'b1;
    end else if (rsp_hsked) begin
      out_flag_r <= 1'b0;
    end
  end

  // Idle, or the outstanding word is coming back right now
  assign new_req_condi = ~out_flag_r | rsp_hsked;

  ////////////////////////////////////////////////////////////
  // Prediction and next address
  ////////////////////////////////////////////////////////////

  // JAL always, branches only backward
  assign prdt_taken = is_jal | (is_bxx & bjp_imm[PC_W-1]);

  // Only a word actually on the response bus may redirect
  assign bjp_req = ifu_rsp_valid & prdt_taken;

  always_comb begin
    if (pipe_flush_req) begin
      pc_add_op1 = pipe_flush_add_op1;
      pc_add_op2 = pipe_flush_add_op2;
    end else if (dly_flush_r) begin
      // pc_r already holds the flush target
      pc_add_op1 = pc_r;
      pc_add_op2 = '0;
    end else if (bjp_req) begin
      pc_add_op1 = pc_r;
      pc_add_op2 = bjp_imm;
    end else if (reset_req_r) begin
      pc_add_op1 = RESET_PC;
      pc_add_op2 = '0;
    end else begin
      pc_add_op1 = pc_r;
      pc_add_op2 = PC_INCR;
    end
  end

  // One shared adder, halfword alignment forced
  assign pc_nxt_pre = pc_add_op1 + pc_add_op2;
  assign pc_nxt     = {pc_nxt_pre[PC_W-1:1], 1'b0};

  // Update on an issued fetch or on any incoming flush
  always_ff @(posedge clk) begin
    if (reset) begin
      pc_r <= RESET_PC;
    end else if (req_hsked | pipe_flush_req) begin
      pc_r <= pc_nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Channel outputs
  ////////////////////////////////////////////////////////////

  // Normal fetch once out of reset, or a flush fetch at any time
  assign ifu_req_valid = (~reset_flag_r | pipe_flush_req) & new_req_condi;
  assign ifu_req_pc    = pc_nxt;

  // Drain freely during a flush, else take word and next request together
  assign ifu_rsp_ready = flush_real | (ir_ready & ifu_req_ready);

  assign ir_load = rsp_hsked & ~flush_real;
  // pc_r is the address of the word in flight
  assign ir_pc   = pc_r;

endmodule

// ==== ir_stage.sv ====
////////////////////////////////////////////////////////////
// Instruction register toward execute
// Holds one fetched word with its PC, bus error and
// prediction, and hands it off on a valid/ready handshake
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module ir_stage (
  input  logic                                clk,
  input  logic                                reset,
  // Load side
  input  logic                                ir_load,
  input  logic [fetch_cfg_pkg::INSTR_W-1:0]   ifu_rsp_instr,
  input  logic                                ifu_rsp_err,
  input  fetch_cfg_pkg::pc_t                  ir_pc,
  input  logic                                prdt_taken,
  output logic                                ir_ready,
  // Flush from execute
  input  logic                                pipe_flush_req,
  // Execute channel
  output logic                                ifu_o_valid,
  input  logic                                ifu_o_ready,
  output logic [fetch_cfg_pkg::INSTR_W-1:0]   ifu_o_ir,
  output fetch_cfg_pkg::pc_t                  ifu_o_pc,
  output logic                                ifu_o_buserr,
  output logic                                ifu_o_prdt_taken
);

  import fetch_cfg_pkg::*;

  logic               ir_valid_r;
  logic               ir_valid_clr;
  logic [INSTR_W-1:0] ir_r;
  pc_t                pc_r;
  logic               err_r;
  logic               taken_r;

  // Emptied by execute taking it, or dropped by a flush
  assign ir_valid_clr = (ir_valid_r & ifu_o_ready) | (ir_valid_r & pipe_flush_req);

  // Load wins over clear
  always_ff @(posedge clk) begin
    if (reset) begin
      ir_valid_r <= 1'b0;
    end else if (ir_load) begin
      ir_valid_r <= 1'b1;
    end else if (ir_valid_clr) begin
      ir_valid_r <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Payload
  ////////////////////////////////////////////////////////////

  // Only written by a fresh word
  always_ff @(posedge clk) begin
    if (ir_load) begin
      ir_r    <= ifu_rsp_instr;
      pc_r    <= ir_pc;
      err_r   <= ifu_rsp_err;
      taken_r <= prdt_taken;
    end
  end

  // Room now, or room after this cycle
  assign ir_ready = ~ir_valid_r | ir_valid_clr;

  assign ifu_o_valid      = ir_valid_r;
  assign ifu_o_ir         = ir_r;
  assign ifu_o_pc         = pc_r;
  assign ifu_o_buserr     = err_r;
  assign ifu_o_prdt_taken = taken_r;

endmodule

// ==== fetch_top.sv ====
////////////////////////////////////////////////////////////
// Instruction fetch stage, top level
// Connects the pre-decoder, the next-PC generator and the
// instruction register. Memory sits on the request and
// response channels, execute on the ifu_o channel
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch_top (
  input  logic                                clk,
  input  logic                                reset,
  // Fetch request channel
  output logic                                ifu_req_valid,
  input  logic                                ifu_req_ready,
  output fetch_cfg_pkg::pc_t                  ifu_req_pc,
  // Fetch response channel
  input  logic                                ifu_rsp_valid,
  output logic                                ifu_rsp_ready,
  input  logic [fetch_cfg_pkg::INSTR_W-1:0]   ifu_rsp_instr,
  input  logic                                ifu_rsp_err,
  // Execute channel
  output logic                                ifu_o_valid,
  input  logic                                ifu_o_ready,
  output logic [fetch_cfg_pkg::INSTR_W-1:0]   ifu_o_ir,
  output fetch_cfg_pkg::pc_t                  ifu_o_pc,
  output logic                                ifu_o_buserr,
  output logic                                ifu_o_prdt_taken,
  // Flush
  input  logic                                pipe_flush_req,
  output logic                                pipe_flush_ack,
  input  fetch_cfg_pkg::pc_t                  pipe_flush_add_op1,
  input  fetch_cfg_pkg::pc_t                  pipe_flush_add_op2
);

  import fetch_cfg_pkg::*;
  import rv_instr_pkg::*;

  instr_u rsp_word;
  logic   is_jal;
  logic   is_bxx;
  pc_t    bjp_imm;
  logic   ir_load;
  pc_t    ir_pc;
  logic   prdt_taken;
  logic   ir_ready;

  // Flush never stalls execute, a late one is tracked inside
  assign pipe_flush_ack = 1'b1;

  // Returning word seen through the format union
  assign rsp_word = ifu_rsp_instr;

  instr_predecode u_instr_predecode (
    .instr   (rsp_word),
    .is_jal  (is_jal),
    .is_bxx  (is_bxx),
    .bjp_imm (bjp_imm)
  );

  next_pc_gen u_next_pc_gen (
    .clk                (clk),
    .reset              (reset),
    .is_jal             (is_jal),
    .is_bxx             (is_bxx),
    .bjp_imm            (bjp_imm),
    .pipe_flush_req     (pipe_flush_req),
    .pipe_flush_add_op1 (pipe_flush_add_op1),
    .pipe_flush_add_op2 (pipe_flush_add_op2),
    .ifu_req_valid      (ifu_req_valid),
    .ifu_req_ready      (ifu_req_ready),
    .ifu_req_pc         (ifu_req_pc),
    .ifu_rsp_valid      (ifu_rsp_valid),
    .ifu_rsp_ready      (ifu_rsp_ready),
    .ir_ready           (ir_ready),
    .ir_load            (ir_load),
    .ir_pc              (ir_pc),
    .prdt_taken         (prdt_taken)
  );

  ir_stage u_ir_stage (
    .clk              (clk),
    .reset            (reset),
    .ir_load          (ir_load),
    .ifu_rsp_instr    (ifu_rsp_instr),
    .ifu_rsp_err      (ifu_rsp_err),
    .ir_pc            (ir_pc),
    .prdt_taken       (prdt_taken),
    .ir_ready         (ir_ready),
    .pipe_flush_req   (pipe_flush_req),
    .ifu_o_valid      (ifu_o_valid),
    .ifu_o_ready      (ifu_o_ready),
    .ifu_o_ir         (ifu_o_ir),
    .ifu_o_pc         (ifu_o_pc),
    .ifu_o_buserr     (ifu_o_buserr),
    .ifu_o_prdt_taken (ifu_o_prdt_taken)
  );

endmodule

// ==== tb_clk_gen.sv ====
////////////////////////////////////////////////////////////
// Testbench clock and reset
// 8 ns clock, reset held over the first two rising edges
// and released on a falling edge
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_clk_gen (
  output logic clk,
  output logic reset
);

  // Half of the 8 ns period
  localparam realtime HALF_PERIOD = 4.0;

  initial begin
    clk = 1'b0;
    forever #(HALF_PERIOD) clk = ~clk;
  end

  // Two rising edges in reset, then let go between edges
  initial begin
    reset = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    reset <= 1'b0;
  end

endmodule

// ==== fetch_top_chk.sv ====
////////////////////////////////////////////////////////////
// Protocol checker bound into the fetch stage
// Watches the request, response and execute channels and
// counts failed rules for the testbench to pick up
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module fetch_top_chk (
  input logic                              clk,
  input logic                              reset,
  input logic                              ifu_req_valid,
  input logic                              ifu_req_ready,
  input fetch_cfg_pkg::pc_t                ifu_req_pc,
  input logic                              ifu_rsp_valid,
  input logic                              ifu_rsp_ready,
  input logic                              ifu_o_valid,
  input logic                              ifu_o_ready,
  input logic [fetch_cfg_pkg::INSTR_W-1:0] ifu_o_ir,
  input fetch_cfg_pkg::pc_t                ifu_o_pc,
  input logic                              ifu_o_buserr,
  input logic                              ifu_o_prdt_taken,
  input logic                              pipe_flush_req
);

  import fetch_cfg_pkg::*;

  int unsigned err_cnt = 0;
  logic        out_pend;

  // Own view of the outstanding fetch, set wins over clear
  always_ff @(posedge clk) begin
    if (reset) begin
      out_pend <= 1'b0;
    end else if (ifu_req_valid && ifu_req_ready) begin
      out_pend <= 1'b1;
    end else if (ifu_rsp_valid && ifu_rsp_ready) begin
      out_pend <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Channel rules
  ////////////////////////////////////////////////////////////

  // A raised request holds address and valid, a new flush may redirect it
  a_req_hold: assert property (@(posedge clk) disable iff (reset)
    ifu_req_valid && !ifu_req_ready && !pipe_flush_req |=>
      pipe_flush_req || (ifu_req_valid && $stable(ifu_req_pc)))
    else begin
      $error("fetch request dropped or changed before its handshake");
      err_cnt++;
    end

  // One fetch in flight, a new one only as the old word is taken
  a_req_single: assert property (@(posedge clk) disable iff (reset)
    ifu_req_valid && ifu_req_ready |-> !out_pend || (ifu_rsp_valid && ifu_rsp_ready))
    else begin
      $error("fetch issued while another one is still outstanding");
      err_cnt++;
    end

  // Held word frozen while execute stalls
  a_o_stable: assert property (@(posedge clk) disable iff (reset)
    ifu_o_valid && !ifu_o_ready && !pipe_flush_req |=>
      ifu_o_valid && $stable(ifu_o_ir) && $stable(ifu_o_pc) &&
      $stable(ifu_o_buserr) && $stable(ifu_o_prdt_taken))
    else begin
      $error("execute outputs changed under back-pressure");
      err_cnt++;
    end

endmodule

bind fetch_top fetch_top_chk u_fetch_top_chk (
  .clk              (clk),
  .reset            (reset),
  .ifu_req_valid    (ifu_req_valid),
  .ifu_req_ready    (ifu_req_ready),
  .ifu_req_pc       (ifu_req_pc),
  .ifu_rsp_valid    (ifu_rsp_valid),
  .ifu_rsp_ready    (ifu_rsp_ready),
  .ifu_o_valid      (ifu_o_valid),
  .ifu_o_ready      (ifu_o_ready),
  .ifu_o_ir         (ifu_o_ir),
  .ifu_o_pc         (ifu_o_pc),
  .ifu_o_buserr     (ifu_o_buserr),
  .ifu_o_prdt_taken (ifu_o_prdt_taken),
  .pipe_flush_req   (pipe_flush_req)
);

// ==== tb_fetch_top.sv ====
////////////////////////////////////////////////////////////
// Testbench for the instruction fetch stage
// Memory model with random ready and 1 to 4 cycle latency,
// random execute back-pressure and flushes. Each handoff
// is followed along the PC chain of a reference predictor
////////////////////////////////////////////////////////////
`timescale 1ns/100ps

module tb_fetch_top;

  import fetch_cfg_pkg::*;
  import rv_instr_pkg::*;

  localparam int          N_HANDOFF   = 400;
  localparam int          CYCLE_LIMIT = 20 * N_HANDOFF;
  localparam logic [31:0] SEED        = 32'd10606;
  // Words in this block come back with the bus error flag
  localparam pc_t         ERR_BASE    = 32'h0000_1080;
  localparam pc_t         ERR_END     = 32'h0000_10c0;

  logic               clk;
  logic               reset;
  logic               ifu_req_valid;
  logic               ifu_req_ready;
  pc_t                ifu_req_pc;
  logic               ifu_rsp_valid;
  logic               ifu_rsp_ready;
  logic [INSTR_W-1:0] ifu_rsp_instr;
  logic               ifu_rsp_err;
  logic               ifu_o_valid;
  logic               ifu_o_ready;
  logic [INSTR_W-1:0] ifu_o_ir;
  pc_t                ifu_o_pc;
  logic               ifu_o_buserr;
  logic               ifu_o_prdt_taken;
  logic               pipe_flush_req;
  logic               pipe_flush_ack;
  pc_t                pipe_flush_add_op1;
  pc_t                pipe_flush_add_op2;

  // Memory model, one fetch in flight at most
  logic [31:0]        rng;
  logic [31:0]        drv_r;
  logic               mem_pend;
  logic               mem_rsp_on;
  pc_t                mem_addr;
  int                 mem_wait;
  // Expected PC chain
  pc_t                exp_pc;
  logic [PC_W:0]      pred;
  int                 handoffs;
  int                 cycle_cnt;

  tb_clk_gen u_tb_clk_gen (
    .clk   (clk),
    .reset (reset)
  );

  fetch_top u_fetch_top (
    .clk                (clk),
    .reset              (reset),
    .ifu_req_valid      (ifu_req_valid),
    .ifu_req_ready      (ifu_req_ready),
    .ifu_req_pc         (ifu_req_pc),
    .ifu_rsp_valid      (ifu_rsp_valid),
    .ifu_rsp_ready      (ifu_rsp_ready),
    .ifu_rsp_instr      (ifu_rsp_instr),
    .ifu_rsp_err        (ifu_rsp_err),
    .ifu_o_valid        (ifu_o_valid),
    .ifu_o_ready        (ifu_o_ready),
    .ifu_o_ir           (ifu_o_ir),
    .ifu_o_pc           (ifu_o_pc),
    .ifu_o_buserr       (ifu_o_buserr),
    .ifu_o_prdt_taken   (ifu_o_prdt_taken),
    .pipe_flush_req     (pipe_flush_req),
    .pipe_flush_ack     (pipe_flush_ack),
    .pipe_flush_add_op1 (pipe_flush_add_op1),
    .pipe_flush_add_op2 (pipe_flush_add_op2)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = lcg_step(rng);
    return rng;
  endfunction

  // Memory contents, a function of the whole address
  function automatic logic [31:0] mem_word(input pc_t addr);
    logic [31:0] h;
    logic [31:0] w;
    pc_t         off;
    h   = lcg_step(lcg_step(SEED ^ addr));
    // 4 to 128 bytes, word multiple
    off = pc_t'({h[10:6], 2'b00}) + pc_t'(4);
    case (h[30:28])
      3'd0: begin
        if (h[11]) begin
          off = -off;
        end
        w = {off[20], off[10:1], off[11], off[19:12], h[16:12], OPC_JAL};
      end
      3'd1, 3'd2: begin
        // 2 is the backward flavour
        if (h[29]) begin
          off = -off;
        end
        w = {off[12], off[10:5], h[21:17], h[26:22], h[14:12], off[4:1], off[11], OPC_BRANCH};
      end
      default: w = {h[24:0], 7'b001_0011};
    endcase
    return w;
  endfunction

  function automatic logic in_err_block(input pc_t addr);
    return (addr >= ERR_BASE) && (addr < ERR_END);
  endfunction

  // Expected prediction as {taken, next PC}
  function automatic logic [PC_W:0] ref_predict(input pc_t pc, input logic [31:0] word);
    pc_t  j_off;
    pc_t  b_off;
    pc_t  nxt;
    logic taken;
    j_off = {{12{word[31]}}, word[19:12], word[20], word[30:21], 1'b0};
    b_off = {{20{word[31]}}, word[7], word[30:25], word[11:8], 1'b0};
    taken = 1'b0;
    nxt   = pc + PC_INCR;
    if (word[6:0] == OPC_JAL) begin
      taken = 1'b1;
      nxt   = pc + j_off;
    end else if ((word[6:0] == OPC_BRANCH) && word[31]) begin
      // backward branch
      taken = 1'b1;
      nxt   = pc + b_off;
    end
    nxt[0] = 1'b0;
    return {taken, nxt};
  endfunction

  task automatic report_error(input string msg);
    $display("ERROR at %t: %s", $realtime, msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "Stopped at the first mismatch");
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus on the falling edge
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    drv_r = next_rand();
    if (reset) begin
      ifu_req_ready  = 1'b0;
      ifu_o_ready    = 1'b0;
      pipe_flush_req = 1'b0;
      ifu_rsp_valid  = 1'b0;
    end else begin
      // Ready three times out of four
      ifu_req_ready  = (drv_r[31:30] != 2'd0);
      ifu_o_ready    = (drv_r[29:28] != 2'd0);
      pipe_flush_req = (drv_r[27:23] == 5'd0) && (handoffs >= 4);
      if (pipe_flush_req) begin
        drv_r              = next_rand();
        pipe_flush_add_op1 = RESET_PC + pc_t'({drv_r[31:26], 2'b00});
        // Odd and halfword sums test the bit 0 clear
        pipe_flush_add_op2 = pc_t'(drv_r[20:16]);
      end
      // Latency countdown, then hold the word until taken
      if (mem_pend && !mem_rsp_on) begin
        if (mem_wait == 0) begin
          mem_rsp_on = 1'b1;
        end else begin
          mem_wait = mem_wait - 1;
        end
      end
      ifu_rsp_valid = mem_rsp_on;
      ifu_rsp_instr = mem_rsp_on ? mem_word(mem_addr) : '0;
      ifu_rsp_err   = mem_rsp_on && in_err_block(mem_addr);
    end
  end

  ////////////////////////////////////////////////////////////
  // Memory handshakes
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      mem_pend   = 1'b0;
      mem_rsp_on = 1'b0;
      mem_wait   = 0;
    end else begin
      // Response first, a new fetch may go out in the same cycle
      if (ifu_rsp_valid && ifu_rsp_ready) begin
        mem_pend   = 1'b0;
        mem_rsp_on = 1'b0;
      end
      if (ifu_req_valid && ifu_req_ready) begin
        assert (!mem_pend)
          else report_error("second fetch issued while one is outstanding");
        mem_pend = 1'b1;
        mem_addr = ifu_req_pc;
        mem_wait = int'(next_rand() >> 30);
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Compare handoffs with the reference chain
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (!reset) begin
      cycle_cnt = cycle_cnt + 1;
      if (ifu_o_valid && ifu_o_ready) begin
        if (handoffs == 0) begin
          assert (ifu_o_pc === RESET_PC)
            else report_error($sformatf("first PC %h, not the reset vector", ifu_o_pc));
        end
        assert (ifu_o_pc === exp_pc)
          else report_error($sformatf("handoff %0d PC %h, expected %h",
                                      handoffs, ifu_o_pc, exp_pc));
        assert (ifu_o_ir === mem_word(exp_pc))
          else report_error($sformatf("PC %h word %h, expected %h",
                                      exp_pc, ifu_o_ir, mem_word(exp_pc)));
        assert (ifu_o_buserr === in_err_block(exp_pc))
          else report_error($sformatf("PC %h bus error flag %b", exp_pc, ifu_o_buserr));
        pred = ref_predict(exp_pc, mem_word(exp_pc));
        assert (ifu_o_prdt_taken === pred[PC_W])
          else report_error($sformatf("PC %h taken %b, expected %b",
                                      exp_pc, ifu_o_prdt_taken, pred[PC_W]));
        exp_pc   = pred[PC_W-1:0];
        handoffs = handoffs + 1;
      end
      // Older words are dropped, fetch restarts at the target
      if (pipe_flush_req) begin
        assert (pipe_flush_ack === 1'b1)
          else report_error("flush not acknowledged");
        exp_pc    = pipe_flush_add_op1 + pipe_flush_add_op2;
        exp_pc[0] = 1'b0;
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // Start and end of the run
  ////////////////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 1, " ns", 0);
    rng                = SEED;
    exp_pc             = RESET_PC;
    handoffs           = 0;
    cycle_cnt          = 0;
    mem_pend           = 1'b0;
    mem_rsp_on         = 1'b0;
    mem_addr           = '0;
    mem_wait           = 0;
    ifu_req_ready      = 1'b0;
    ifu_rsp_valid      = 1'b0;
    ifu_rsp_instr      = '0;
    ifu_rsp_err        = 1'b0;
    ifu_o_ready        = 1'b0;
    pipe_flush_req     = 1'b0;
    pipe_flush_add_op1 = '0;
    pipe_flush_add_op2 = '0;
    while ((handoffs < N_HANDOFF) && (cycle_cnt < CYCLE_LIMIT) &&
           (u_fetch_top.u_fetch_top_chk.err_cnt == 0)) begin
      @(negedge clk);
    end
    if ((handoffs >= N_HANDOFF) && (u_fetch_top.u_fetch_top_chk.err_cnt == 0)) begin
      $display("Simulation finished: PASS");
      $finish;
    end else begin
      if (u_fetch_top.u_fetch_top_chk.err_cnt != 0) begin
        $display("A channel protocol rule was broken, see the checker error above");
      end else begin
        $display("Timeout with %0d of %0d instructions handed off after %0d cycles",
                 handoffs, N_HANDOFF, cycle_cnt);
      end
      $display("Simulation finished: FAIL");
      $fatal(1, "Run ended early");
    end
  end

endmodule

// ==== fetch_top.f ====
fetch_cfg_pkg.sv
rv_instr_pkg.sv
instr_predecode.sv
next_pc_gen.sv
ir_stage.sv
fetch_top.sv
tb_clk_gen.sv
fetch_top_chk.sv
tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_top

sources:
  # Packages first, then the RTL bottom up
  - fetch_cfg_pkg.sv
  - rv_instr_pkg.sv
  - instr_predecode.sv
  - next_pc_gen.sv
  - ir_stage.sv
  - fetch_top.sv
  # Testbench with the bound checker
  - target: test
    files:
      - tb_clk_gen.sv
      - fetch_top_chk.sv
      - tb_fetch_top.sv
